//--- logic/tscPkg.sv
package tscPkg;

    localparam int wordSize = 16;

    typedef logic [wordSize-1:0] word;

    // opcodes
    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opBgz   = 4'd2;
    localparam logic [3:0] opBlz   = 4'd3;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opOri   = 4'd5;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opJal   = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // func field of R-type words
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnHlt = 6'd29;

    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr  = 3'd3;
    localparam logic [2:0] aluNot = 3'd4;
    localparam logic [2:0] aluTcp = 3'd5;
    localparam logic [2:0] aluShl = 3'd6;
    localparam logic [2:0] aluShr = 3'd7;

    // sequencer states
    localparam logic [2:0] stFetch = 3'd0;
    localparam logic [2:0] stExec  = 3'd1;
    localparam logic [2:0] stMem   = 3'd2;
    localparam logic [2:0] stWb    = 3'd3;
    localparam logic [2:0] stHalt  = 3'd4;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } rFormat;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iFormat;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jFormat;

    // one instruction word seen through its three formats
    typedef union packed {
        rFormat rView;
        iFormat iView;
        jFormat jView;
    } instrWord;

endpackage

//--- logic/regPortIf.sv
`timescale 1ns/10ps

interface regPortIf;

    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [1:0]  writeReg;
    tscPkg::word writeData;
    logic        writeEn;
    tscPkg::word readData1;     // value of rs
    tscPkg::word readData2;     // value of rt

    modport dp (
        output rs, rt, writeReg, writeData, writeEn,
        input  readData1, readData2
    );

    modport rf (
        input  rs, rt, writeReg, writeData, writeEn,
        output readData1, readData2
    );

endinterface

//--- logic/regFile.sv
`timescale 1ns/10ps

module regFile (
    input logic clk,
    input logic arstN,
    regPortIf.rf regs
);

    tscPkg::word regArray [0:3];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regArray[i] <= '0;
            end
        end else if (regs.writeEn) begin
            regArray[regs.writeReg] <= regs.writeData;
        end
    end

    // both reads are combinational
    assign regs.readData1 = regArray[regs.rs];
    assign regs.readData2 = regArray[regs.rt];

    // the datapath must hand over a clean value on every write
    writeDataKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        regs.writeEn |-> !$isunknown(regs.writeData)
    );

endmodule

//--- logic/alu.sv
`timescale 1ns/10ps

module alu (
    input  tscPkg::word a,
    input  tscPkg::word b,
    input  logic [2:0]  op,
    output tscPkg::word y
);

    always_comb begin
        case (op)
            tscPkg::aluAdd: y = a + b;
            tscPkg::aluSub: y = a - b;
            tscPkg::aluAnd: y = a & b;
            tscPkg::aluOr:  y = a | b;
            tscPkg::aluNot: y = ~a;
            tscPkg::aluTcp: y = ~a + 16'd1;
            tscPkg::aluShl: y = {a[tscPkg::wordSize-2:0], 1'b0};
            // sign bit is kept on the right shift
            tscPkg::aluShr: y = {a[tscPkg::wordSize-1], a[tscPkg::wordSize-1:1]};
            default:        y = a + b;
        endcase
    end

endmodule

//--- logic/branchUnit.sv
`timescale 1ns/10ps

module branchUnit (
    input  tscPkg::instrWord instr,
    input  tscPkg::word      pc,
    input  tscPkg::word      rs1,
    input  tscPkg::word      rs2,
    output tscPkg::word      nextPc,
    output tscPkg::word      linkValue
);

    tscPkg::word pcPlus1;
    tscPkg::word branchTarget;
    tscPkg::word jumpTarget;
    logic        taken;

    assign pcPlus1      = pc + 16'd1;
    assign branchTarget = pcPlus1 + {{8{instr.iView.imm[7]}}, instr.iView.imm};
    assign jumpTarget   = {pc[15:12], instr.jView.target};   // stays in the current 4K page

    always_comb begin
        case (instr.iView.opcode)
            tscPkg::opBne: taken = (rs1 != rs2);
            tscPkg::opBeq: taken = (rs1 == rs2);
            tscPkg::opBgz: taken = ($signed(rs1) > 16'sd0);
            tscPkg::opBlz: taken = ($signed(rs1) < 16'sd0);
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        case (instr.iView.opcode)
            tscPkg::opBne, tscPkg::opBeq,
            tscPkg::opBgz, tscPkg::opBlz: nextPc = taken ? branchTarget : pcPlus1;
            tscPkg::opJmp, tscPkg::opJal: nextPc = jumpTarget;
            tscPkg::opRtype: begin
                if (instr.rView.func == tscPkg::fnJpr || instr.rView.func == tscPkg::fnJrl) begin
                    nextPc = rs1;
                end else begin
                    nextPc = pcPlus1;
                end
            end
            default: nextPc = pcPlus1;
        endcase
    end

    assign linkValue = pcPlus1;

endmodule

//--- logic/cpuSequencer.sv
`timescale 1ns/10ps

module cpuSequencer (
    input  logic             clk,
    input  logic             arstN,
    input  tscPkg::instrWord instr,
    input  logic             inputReady,
    input  logic             ackOutput,
    output logic             readM,
    output logic             writeM,
    output logic             irLoad,
    output logic             pcLoad,
    output logic             regWrite,
    output logic             addrSel,
    output logic             halted
);

    logic [2:0] state;
    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = instr.rView.opcode;
    assign func   = instr.rView.func;

    function automatic logic writesReg(input tscPkg::instrWord i);
        case (i.rView.opcode)
            tscPkg::opAdi, tscPkg::opOri, tscPkg::opLhi,
            tscPkg::opLwd, tscPkg::opJal: return 1'b1;
            tscPkg::opRtype: return (i.rView.func <= tscPkg::fnShr) ||
                                    (i.rView.func == tscPkg::fnJrl);
            default: return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= tscPkg::stFetch;
            readM  <= 1'b0;
            writeM <= 1'b0;
        end else begin
            case (state)
                tscPkg::stFetch: begin
                    if (readM && inputReady) begin
                        readM <= 1'b0;
                        state <= tscPkg::stExec;
                    end else begin
                        readM <= 1'b1;     // first request right after reset
                    end
                end
                tscPkg::stExec: begin
                    if (opcode == tscPkg::opRtype && func == tscPkg::fnHlt) begin
                        state <= tscPkg::stHalt;
                    end else if (opcode == tscPkg::opLwd) begin
                        readM <= 1'b1;
                        state <= tscPkg::stMem;
                    end else if (opcode == tscPkg::opSwd) begin
                        writeM <= 1'b1;
                        state  <= tscPkg::stMem;
                    end else begin
                        state <= tscPkg::stWb;
                    end
                end
                tscPkg::stMem: begin
                    // wait out the memory, however long it stalls
                    if (readM && inputReady) begin
                        readM <= 1'b0;
                        state <= tscPkg::stWb;
                    end
                    if (writeM && ackOutput) begin
                        writeM <= 1'b0;
                        state  <= tscPkg::stWb;
                    end
                end
                tscPkg::stWb: begin
                    readM <= 1'b1;         // next fetch starts at once
                    state <= tscPkg::stFetch;
                end
                default: state <= tscPkg::stHalt;
            endcase
        end
    end

    assign irLoad   = (state == tscPkg::stFetch) && readM && inputReady;
    assign pcLoad   = (state == tscPkg::stWb);
    assign regWrite = pcLoad && writesReg(instr);
    assign addrSel  = (state == tscPkg::stMem);
    assign halted   = (state == tscPkg::stHalt);

    noDualRequest: assert property (
        @(posedge clk) disable iff (!arstN) !(readM && writeM)
    );

    readHeld: assert property (
        @(posedge clk) disable iff (!arstN) readM && !inputReady |=> readM
    );

    quietHalt: assert property (
        @(posedge clk) disable iff (!arstN) halted |=> halted && !readM && !writeM
    );

endmodule

//--- logic/cpuDatapath.sv
`timescale 1ns/10ps

module cpuDatapath (
    input  logic             clk,
    input  logic             arstN,
    input  logic             irLoad,
    input  logic             pcLoad,
    input  logic             regWrite,
    input  logic             addrSel,
    input  tscPkg::word      memRdata,
    output tscPkg::word      memAddr,
    output tscPkg::word      memWdata,
    output tscPkg::instrWord instr,
    regPortIf.dp             regs,
    output tscPkg::word      aluA,
    output tscPkg::word      aluB,
    output logic [2:0]       aluOp,
    input  tscPkg::word      aluY,
    output tscPkg::word      pc,
    input  tscPkg::word      nextPc,
    input  tscPkg::word      linkValue
);

    tscPkg::word loadData;
    tscPkg::word immSext;
    tscPkg::word immZext;
    logic [3:0]  opcode;
    logic [5:0]  func;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (irLoad) begin
            instr <= memRdata;
        end
        loadData <= memRdata;   // holds the LWD word through writeback
    end

    assign opcode  = instr.rView.opcode;
    assign func    = instr.rView.func;
    assign immSext = {{8{instr.iView.imm[7]}}, instr.iView.imm};
    assign immZext = {8'h00, instr.iView.imm};

    assign regs.rs = instr.rView.rs;
    assign regs.rt = instr.rView.rt;

    assign aluA = regs.readData1;

    always_comb begin
        case (opcode)
            tscPkg::opRtype: aluB = regs.readData2;
            tscPkg::opOri:   aluB = immZext;
            default:         aluB = immSext;   // ADI and load/store offset
        endcase
    end

    always_comb begin
        aluOp = tscPkg::aluAdd;
        if (opcode == tscPkg::opOri) begin
            aluOp = tscPkg::aluOr;
        end else if (opcode == tscPkg::opRtype) begin
            case (func)
                tscPkg::fnSub: aluOp = tscPkg::aluSub;
                tscPkg::fnAnd: aluOp = tscPkg::aluAnd;
                tscPkg::fnOrr: aluOp = tscPkg::aluOr;
                tscPkg::fnNot: aluOp = tscPkg::aluNot;
                tscPkg::fnTcp: aluOp = tscPkg::aluTcp;
                tscPkg::fnShl: aluOp = tscPkg::aluShl;
                tscPkg::fnShr: aluOp = tscPkg::aluShr;
                tscPkg::fnAdd: aluOp = tscPkg::aluAdd;
                default:       aluOp = tscPkg::aluAdd;
            endcase
        end
    end

    // link register is r2
    always_comb begin
        case (opcode)
            tscPkg::opRtype: regs.writeReg = (func == tscPkg::fnJrl) ? 2'd2 : instr.rView.rd;
            tscPkg::opJal:   regs.writeReg = 2'd2;
            default:         regs.writeReg = instr.iView.rt;
        endcase
    end

    always_comb begin
        case (opcode)
            tscPkg::opLhi:   regs.writeData = {instr.iView.imm, 8'h00};
            tscPkg::opLwd:   regs.writeData = loadData;
            tscPkg::opJal:   regs.writeData = linkValue;
            tscPkg::opRtype: regs.writeData = (func == tscPkg::fnJrl) ? linkValue : aluY;
            default:         regs.writeData = aluY;
        endcase
    end

    assign regs.writeEn = regWrite;

    assign memAddr  = addrSel ? aluY : pc;
    assign memWdata = regs.readData2;   // SWD stores rt

endmodule

//--- logic/tscCore.sv
`timescale 1ns/10ps

module tscCore (
    input  logic        clk,
    input  logic        arstN,
    output logic        readM,
    output logic        writeM,
    output tscPkg::word memAddr,
    output tscPkg::word memWdata,
    input  tscPkg::word memRdata,
    input  logic        inputReady,
    input  logic        ackOutput,
    output logic        halted
);

    tscPkg::instrWord instr;
    logic             irLoad;
    logic             pcLoad;
    logic             regWrite;
    logic             addrSel;
    tscPkg::word      aluA;
    tscPkg::word      aluB;
    logic [2:0]       aluOp;
    tscPkg::word      aluY;
    tscPkg::word      pc;
    tscPkg::word      nextPc;
    tscPkg::word      linkValue;

    regPortIf regPort ();

    cpuSequencer i_cpuSequencer (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .readM      (readM),
        .writeM     (writeM),
        .irLoad     (irLoad),
        .pcLoad     (pcLoad),
        .regWrite   (regWrite),
        .addrSel    (addrSel),
        .halted     (halted)
    );

    cpuDatapath i_cpuDatapath (
        .clk       (clk),
        .arstN     (arstN),
        .irLoad    (irLoad),
        .pcLoad    (pcLoad),
        .regWrite  (regWrite),
        .addrSel   (addrSel),
        .memRdata  (memRdata),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .instr     (instr),
        .regs      (regPort.dp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluOp     (aluOp),
        .aluY      (aluY),
        .pc        (pc),
        .nextPc    (nextPc),
        .linkValue (linkValue)
    );

    regFile i_regFile (
        .clk   (clk),
        .arstN (arstN),
        .regs  (regPort.rf)
    );

    alu i_alu (
        .a  (aluA),
        .b  (aluB),
        .op (aluOp),
        .y  (aluY)
    );

    // branch compare reads the same register ports as the datapath
    branchUnit i_branchUnit (
        .instr     (instr),
        .pc        (pc),
        .rs1       (regPort.readData1),
        .rs2       (regPort.readData2),
        .nextPc    (nextPc),
        .linkValue (linkValue)
    );

endmodule

//--- bench/tscRefModel.svh
// instruction-level model, runs the program image and queues the expected bus traffic
function automatic int runReference();
    tscPkg::word      image [0:4095];
    tscPkg::word      r [0:3];
    tscPkg::instrWord ins;
    tscPkg::word      a;
    tscPkg::word      b;
    tscPkg::word      sext;
    tscPkg::word      addr;
    tscPkg::word      pcRef;
    tscPkg::word      pcNext;
    int               steps;
    logic             done;
    for (int i = 0; i < 4096; i++) begin
        image[i] = progMem[i];
    end
    for (int i = 0; i < 4; i++) begin
        r[i] = '0;
    end
    pcRef = '0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 2000) begin
        expFetch.push_back(pcRef);
        ins    = image[pcRef[11:0]];
        steps++;
        a      = r[ins.iView.rs];
        b      = r[ins.iView.rt];
        sext   = {{8{ins.iView.imm[7]}}, ins.iView.imm};
        addr   = a + sext;    // load/store address
        pcNext = pcRef + 16'd1;
        case (ins.iView.opcode)
            tscPkg::opBne: if (a != b) pcNext = pcNext + sext;
            tscPkg::opBeq: if (a == b) pcNext = pcNext + sext;
            tscPkg::opBgz: if ($signed(a) > 0) pcNext = pcNext + sext;
            tscPkg::opBlz: if ($signed(a) < 0) pcNext = pcNext + sext;
            tscPkg::opAdi: r[ins.iView.rt] = a + sext;
            tscPkg::opOri: r[ins.iView.rt] = a | {8'h00, ins.iView.imm};
            tscPkg::opLhi: r[ins.iView.rt] = {ins.iView.imm, 8'h00};
            tscPkg::opLwd: r[ins.iView.rt] = image[addr[11:0]];
            tscPkg::opSwd: begin
                image[addr[11:0]] = b;
                expWAddr.push_back(addr);
                expWData.push_back(b);
            end
            tscPkg::opJmp: pcNext = {pcRef[15:12], ins.jView.target};
            tscPkg::opJal: begin
                r[2]   = pcRef + 16'd1;
                pcNext = {pcRef[15:12], ins.jView.target};
            end
            tscPkg::opRtype: begin
                case (ins.rView.func)
                    tscPkg::fnAdd: r[ins.rView.rd] = a + b;
                    tscPkg::fnSub: r[ins.rView.rd] = a - b;
                    tscPkg::fnAnd: r[ins.rView.rd] = a & b;
                    tscPkg::fnOrr: r[ins.rView.rd] = a | b;
                    tscPkg::fnNot: r[ins.rView.rd] = ~a;
                    tscPkg::fnTcp: r[ins.rView.rd] = -a;
                    tscPkg::fnShl: r[ins.rView.rd] = a << 1;
                    tscPkg::fnShr: r[ins.rView.rd] = $signed(a) >>> 1;
                    tscPkg::fnJpr: pcNext = a;
                    tscPkg::fnJrl: begin
                        r[2]   = pcRef + 16'd1;   // link taken before the jump
                        pcNext = a;
                    end
                    tscPkg::fnHlt: done = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        pcRef = pcNext;
    end
    return steps;
endfunction

//--- bench/tscTb.sv
`timescale 1ns/10ps

module tscTb;

    logic        clk;
    logic        arstN;
    logic        readM;
    logic        writeM;
    tscPkg::word memAddr;
    tscPkg::word memWdata;
    tscPkg::word memRdata;
    logic        inputReady;
    logic        ackOutput;
    logic        halted;

    tscPkg::word progMem [0:4095];
    tscPkg::word memArray [0:4095];   // live memory seen by the core
    tscPkg::word expFetch [$];
    tscPkg::word expWAddr [$];
    tscPkg::word expWData [$];
    tscPkg::word seenFetch [$];
    tscPkg::word seenWAddr [$];
    tscPkg::word seenWData [$];
    int          refSteps = 0;
    int          refWrites = 0;
    int          fetchCount = 0;
    int          writeCount = 0;

    `include "tscRefModel.svh"

    tscCore i_tscCore (
        .clk        (clk),
        .arstN      (arstN),
        .readM      (readM),
        .writeM     (writeM),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memRdata   (memRdata),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .halted     (halted)
    );

    function automatic tscPkg::word encodeR(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input logic [5:0] func);
        return {tscPkg::opRtype, rs, rt, rd, func};
    endfunction

    function automatic tscPkg::word encodeI(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 4096; i++) begin
            progMem[i] = tscPkg::word'(i * 16'h9e37) ^ 16'h5a5a;
        end
        progMem[0]  = encodeI(tscPkg::opLhi, 0, 1, 8'h01);      // r1 = data base 0x0100
        progMem[1]  = encodeI(tscPkg::opAdi, 0, 2, 8'hfd);
        progMem[2]  = encodeI(tscPkg::opOri, 0, 3, 8'ha5);
        progMem[3]  = encodeR(2, 3, 0, tscPkg::fnAdd);
        progMem[4]  = encodeR(0, 2, 0, tscPkg::fnSub);
        progMem[5]  = encodeI(tscPkg::opSwd, 1, 0, 8'h00);
        progMem[6]  = encodeR(2, 1, 0, tscPkg::fnAnd);
        progMem[7]  = encodeR(0, 3, 0, tscPkg::fnOrr);
        progMem[8]  = encodeI(tscPkg::opSwd, 1, 0, 8'h01);
        progMem[9]  = encodeR(0, 0, 0, tscPkg::fnNot);
        progMem[10] = encodeR(0, 0, 0, tscPkg::fnTcp);
        progMem[11] = encodeI(tscPkg::opSwd, 1, 0, 8'h02);
        progMem[12] = encodeR(2, 0, 0, tscPkg::fnShl);
        progMem[13] = encodeR(0, 0, 0, tscPkg::fnShr);          // sign must stay on a negative value
        progMem[14] = encodeI(tscPkg::opSwd, 1, 0, 8'h03);
        progMem[15] = encodeI(tscPkg::opLwd, 1, 0, 8'h00);
        progMem[16] = encodeI(tscPkg::opSwd, 1, 0, 8'h08);      // copy of the loaded word
        progMem[17] = encodeI(tscPkg::opAdi, 3, 0, 8'h00);
        progMem[18] = encodeI(tscPkg::opBne, 0, 3, 8'h05);      // not taken
        progMem[19] = encodeI(tscPkg::opBeq, 0, 3, 8'h01);
        progMem[20] = encodeR(0, 0, 0, tscPkg::fnHlt);
        progMem[21] = encodeI(tscPkg::opBgz, 2, 0, 8'h05);      // not taken
        progMem[22] = encodeI(tscPkg::opBgz, 0, 0, 8'h01);
        progMem[23] = encodeR(0, 0, 0, tscPkg::fnHlt);
        progMem[24] = encodeI(tscPkg::opBlz, 0, 0, 8'h05);      // not taken
        progMem[25] = encodeI(tscPkg::opBlz, 2, 0, 8'h01);
        progMem[26] = encodeR(0, 0, 0, tscPkg::fnHlt);
        progMem[27] = encodeI(tscPkg::opBne, 0, 2, 8'h01);
        progMem[28] = encodeR(0, 0, 0, tscPkg::fnHlt);
        progMem[29] = encodeI(tscPkg::opBeq, 0, 2, 8'h05);      // not taken
        progMem[30] = {tscPkg::opJal, 12'd40};
        progMem[31] = encodeI(tscPkg::opSwd, 1, 2, 8'h0a);      // link from JRL
        progMem[32] = encodeI(tscPkg::opAdi, 2, 0, 8'h02);
        progMem[33] = encodeR(0, 0, 0, tscPkg::fnJpr);
        progMem[40] = encodeI(tscPkg::opSwd, 1, 2, 8'h09);      // link from JAL
        progMem[41] = encodeR(2, 0, 0, tscPkg::fnJrl);
        progMem[44] = encodeI(tscPkg::opLhi, 0, 3, 8'h00);
        progMem[45] = encodeI(tscPkg::opAdi, 3, 3, 8'h03);
        progMem[46] = encodeI(tscPkg::opAdi, 3, 3, 8'hff);
        progMem[47] = encodeI(tscPkg::opBgz, 3, 0, 8'hfe);      // backward loop
        progMem[48] = {tscPkg::opJmp, 12'd50};
        progMem[49] = encodeR(0, 0, 0, tscPkg::fnHlt);
        progMem[50] = encodeI(tscPkg::opSwd, 1, 3, 8'h0b);
        progMem[51] = encodeR(0, 0, 0, tscPkg::fnHlt);
        for (int i = 0; i < 4096; i++) begin
            memArray[i] = progMem[i];
        end
    endtask

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkFetch(input tscPkg::word addr);
        tscPkg::word expAddr;
        if (expFetch.size() == 0) begin
            stopRun($sformatf("The core fetched from %h after the last expected fetch.", addr));
        end else begin
            expAddr = expFetch.pop_front();
            if (addr !== expAddr) begin
                stopRun($sformatf("[ERROR] %0t: fetch from %h, expected %h",
                                  $time, addr, expAddr));
            end else begin
                fetchCount++;
            end
        end
    endtask

    task automatic checkWrite(input tscPkg::word addr, input tscPkg::word data);
        tscPkg::word expAddr;
        tscPkg::word expData;
        if (expWAddr.size() == 0) begin
            stopRun($sformatf("The core wrote %h to %h, but no write was expected.", data, addr));
        end else begin
            expAddr = expWAddr.pop_front();
            expData = expWData.pop_front();
            if (addr !== expAddr || data !== expData) begin
                stopRun($sformatf("[ERROR] %0t: write %h to %h, expected %h to %h",
                                  $time, data, addr, expData, expAddr));
            end else begin
                writeCount++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // answers one request at a time after 0 to 3 stall cycles
    initial begin : memoryModel
        tscPkg::instrWord fetched;
        int unsigned      delay;
        logic             loadNext;
        void'($urandom(32'he1ba_0bbc));
        loadNext = 1'b0;
        forever begin
            @(negedge clk);
            if (readM || writeM) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                if (readM) begin
                    memRdata   = memArray[memAddr[11:0]];
                    inputReady = 1'b1;
                    if (loadNext) begin
                        loadNext = 1'b0;
                    end else begin
                        seenFetch.push_back(memAddr);
                        fetched  = memArray[memAddr[11:0]];
                        loadNext = (fetched.rView.opcode == tscPkg::opLwd);  // data read follows
                    end
                end else begin
                    memArray[memAddr[11:0]] = memWdata;
                    seenWAddr.push_back(memAddr);
                    seenWData.push_back(memWdata);
                    ackOutput = 1'b1;
                end
                @(negedge clk);
                inputReady = 1'b0;
                ackOutput  = 1'b0;
            end
        end
    end

    initial begin : compare
        forever begin
            @(posedge clk);
            while (seenFetch.size() > 0) begin
                checkFetch(seenFetch.pop_front());
            end
            while (seenWAddr.size() > 0) begin
                checkWrite(seenWAddr.pop_front(), seenWData.pop_front());
            end
        end
    end

    // 40 cycles covers one instruction with two 3-cycle memory stalls and some slack
    initial begin : watchdog
        wait (refSteps > 0);
        repeat (refSteps * 40 + 10) @(posedge clk);
        stopRun("The core did not halt in time.");
    end

    initial begin : mainFlow
        arstN      = 1'b0;
        memRdata   = '0;
        inputReady = 1'b0;
        ackOutput  = 1'b0;
        loadProgram();
        refSteps  = runReference();
        refWrites = expWAddr.size();
        repeat (5) @(posedge clk);
        @(negedge clk);
        checkLevel(readM, 1'b0, "readM in reset");
        checkLevel(writeM, 1'b0, "writeM in reset");
        checkLevel(halted, 1'b0, "halted in reset");
        arstN = 1'b1;
        wait (halted === 1'b1);
        repeat (10) begin
            @(negedge clk);
            checkLevel(readM, 1'b0, "readM after halt");
            checkLevel(writeM, 1'b0, "writeM after halt");
            checkLevel(halted, 1'b1, "halted");
        end
        if (expFetch.size() == 0 && fetchCount == refSteps && writeCount == refWrites) begin
            $display("Verification passed");
            $finish;
        end else begin
            stopRun($sformatf("The core halted after %0d fetches and %0d writes, not %0d and %0d.",
                              fetchCount, writeCount, refSteps, refWrites));
        end
    end

endmodule

//--- tsc.f
+incdir+bench
logic/tscPkg.sv
logic/regPortIf.sv
logic/regFile.sv
logic/alu.sv
logic/branchUnit.sv
logic/cpuSequencer.sv
logic/cpuDatapath.sv
logic/tscCore.sv
bench/tscTb.sv
